// File: src/soc_pkg.sv
package soc_pkg;

	// ====================================================================
	// Bus geometry
	// ====================================================================

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// On-chip RAM, word addressed
	localparam int RAM_DEPTH = 512;
	localparam int RAM_AW = 9;

	// Red LED register
	localparam int LED_W = 10;

	// ====================================================================
	// Address map and register offsets
	// ====================================================================

	// Top nibble of the bus address, other values are unmapped
	typedef enum logic [3:0] {
		REGION_RAM   = 4'h1,
		REGION_LED   = 4'h4,
		REGION_DMA   = 4'h9,
		REGION_TIMER = 4'ha
	} region_e;

	// DMA registers, word offset in address bits 3:2
	localparam logic [1:0] DMA_REG_SRC = 2'd0;
	localparam logic [1:0] DMA_REG_DST = 2'd1;
	localparam logic [1:0] DMA_REG_COUNT = 2'd2;
	localparam logic [1:0] DMA_REG_STATUS = 2'd3;

	// Timer registers
	localparam logic [1:0] TIMER_REG_TIME = 2'd0;
	localparam logic [1:0] TIMER_REG_CMP = 2'd1;

	// ====================================================================
	// State machines
	// ====================================================================

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_HOST,
		ARB_DMA
	} arb_state_e;

	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_WRITE
	} dma_state_e;

endpackage

// File: src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input  logic i_clock,
	input  logic i_rst,

	// Host master
	input  logic i_host_request,
	input  logic i_host_rw,
	input  logic [soc_pkg::ADDR_W-1:0] i_host_address,
	input  logic [soc_pkg::DATA_W-1:0] i_host_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_host_rdata,
	output logic o_host_ready,

	// DMA master
	input  logic i_dma_request,
	input  logic i_dma_rw,
	input  logic [soc_pkg::ADDR_W-1:0] i_dma_address,
	input  logic [soc_pkg::DATA_W-1:0] i_dma_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_dma_rdata,
	output logic o_dma_ready,

	// System bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [soc_pkg::ADDR_W-1:0] o_bus_address,
	output logic [soc_pkg::DATA_W-1:0] o_bus_wdata,
	input  logic [soc_pkg::DATA_W-1:0] i_bus_rdata,
	input  logic i_bus_ready
);

	soc_pkg::arb_state_e state;

	logic [soc_pkg::DATA_W-1:0] rdata;
	logic host_want;
	logic dma_want;

	// A master still seeing its ready pulse has not dropped request yet
	assign host_want = i_host_request && !o_host_ready;
	assign dma_want = i_dma_request && !o_dma_ready;

	assign o_host_rdata = rdata;
	assign o_dma_rdata = rdata;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= soc_pkg::ARB_IDLE;
			o_bus_request <= 1'b0;
			o_host_ready <= 1'b0;
			o_dma_ready <= 1'b0;
		end else begin
			o_host_ready <= 1'b0;
			o_dma_ready <= 1'b0;
			case (state)
				soc_pkg::ARB_IDLE: begin
					// Host wins a tie
					if (host_want) begin
						state <= soc_pkg::ARB_HOST;
						o_bus_request <= 1'b1;
					end else if (dma_want) begin
						state <= soc_pkg::ARB_DMA;
						o_bus_request <= 1'b1;
					end
				end
				soc_pkg::ARB_HOST: begin
					if (i_bus_ready) begin
						state <= soc_pkg::ARB_IDLE;
						o_bus_request <= 1'b0;
						o_host_ready <= 1'b1;
					end
				end
				soc_pkg::ARB_DMA: begin
					if (i_bus_ready) begin
						state <= soc_pkg::ARB_IDLE;
						o_bus_request <= 1'b0;
						o_dma_ready <= 1'b1;
					end
				end
				default: state <= soc_pkg::ARB_IDLE;
			endcase
		end
	end

	// Transfer fields latched at grant, read data at completion
	always_ff @(posedge i_clock) begin
		if (state == soc_pkg::ARB_IDLE) begin
			if (host_want) begin
				o_bus_rw <= i_host_rw;
				o_bus_address <= i_host_address;
				o_bus_wdata <= i_host_wdata;
			end else if (dma_want) begin
				o_bus_rw <= i_dma_rw;
				o_bus_address <= i_dma_address;
				o_bus_wdata <= i_dma_wdata;
			end
		end
		if (i_bus_ready) begin
			rdata <= i_bus_rdata;
		end
	end

endmodule

// File: src/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric (
	input  logic i_clock,
	input  logic i_rst,

	// System bus
	input  logic i_bus_request,
	input  logic i_bus_rw,
	input  logic [soc_pkg::ADDR_W-1:0] i_bus_address,
	input  logic [soc_pkg::DATA_W-1:0] i_bus_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_bus_rdata,
	output logic o_bus_ready,

	// Slave returns
	input  logic [soc_pkg::DATA_W-1:0] i_ram_rdata,
	input  logic i_ram_ready,
	input  logic [soc_pkg::DATA_W-1:0] i_timer_rdata,
	input  logic i_timer_ready,
	input  logic [soc_pkg::DATA_W-1:0] i_dma_rdata,
	input  logic i_dma_ready,

	// Slave requests
	output logic o_ram_request,
	output logic o_timer_request,
	output logic o_dma_request,

	output logic [soc_pkg::LED_W-1:0] o_led
);

	logic [3:0] region;
	logic ram_sel;
	logic timer_sel;
	logic dma_sel;
	logic led_sel;
	logic local_sel;
	logic local_ready;

	assign region = i_bus_address[soc_pkg::ADDR_W-1 -: 4];

	assign ram_sel = region == soc_pkg::REGION_RAM;
	assign timer_sel = region == soc_pkg::REGION_TIMER;
	assign dma_sel = region == soc_pkg::REGION_DMA;
	assign led_sel = region == soc_pkg::REGION_LED;

	// LED and unmapped space are answered here
	assign local_sel = !(ram_sel || timer_sel || dma_sel);

	assign o_ram_request = i_bus_request && ram_sel;
	assign o_timer_request = i_bus_request && timer_sel;
	assign o_dma_request = i_bus_request && dma_sel;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_led <= '0;
			local_ready <= 1'b0;
		end else begin
			local_ready <= i_bus_request && local_sel && !local_ready;
			if (i_bus_request && led_sel && i_bus_rw && !local_ready) begin
				o_led <= i_bus_wdata[soc_pkg::LED_W-1:0];
			end
		end
	end

	// Return path follows the selected region
	always_comb begin
		o_bus_rdata = '0;
		o_bus_ready = local_ready;
		if (ram_sel) begin
			o_bus_rdata = i_ram_rdata;
			o_bus_ready = i_ram_ready;
		end else if (timer_sel) begin
			o_bus_rdata = i_timer_rdata;
			o_bus_ready = i_timer_ready;
		end else if (dma_sel) begin
			o_bus_rdata = i_dma_rdata;
			o_bus_ready = i_dma_ready;
		end else if (led_sel) begin
			o_bus_rdata = {{(soc_pkg::DATA_W - soc_pkg::LED_W){1'b0}}, o_led};
		end
	end

endmodule

// File: src/block_ram.sv
`timescale 1ns/1ps

module block_ram (
	input  logic i_clock,
	input  logic i_request,
	input  logic i_rw,
	input  logic [soc_pkg::ADDR_W-1:0] i_address,
	input  logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready
);

	logic [soc_pkg::DATA_W-1:0] mem [soc_pkg::RAM_DEPTH];
	logic [soc_pkg::RAM_AW-1:0] index;
	logic access;

	// Word index, byte offset dropped
	assign index = i_address[soc_pkg::RAM_AW+1:2];

	// Request is still high in the cycle ready is out, act only once
	assign access = i_request && !o_ready;

	always_ff @(posedge i_clock) begin
		o_ready <= access;
		if (access) begin
			if (i_rw) begin
				mem[index] <= i_wdata;
			end else begin
				o_rdata <= mem[index];
			end
		end
	end

endmodule

// File: src/timer.sv
`timescale 1ns/1ps

module timer (
	input  logic i_clock,
	input  logic i_rst,
	input  logic i_request,
	input  logic i_rw,
	input  logic [soc_pkg::ADDR_W-1:0] i_address,
	input  logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_timer_irq
);

	logic [soc_pkg::DATA_W-1:0] mtime;
	logic [soc_pkg::DATA_W-1:0] compare;
	logic [1:0] offset;
	logic access;

	assign offset = i_address[3:2];
	assign access = i_request && !o_ready;

	// Level interrupt, cleared by moving compare ahead
	assign o_timer_irq = mtime >= compare;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			mtime <= '0;
			compare <= '1;
			o_ready <= 1'b0;
		end else begin
			o_ready <= access;
			mtime <= mtime + 1'b1;
			if (access && i_rw) begin
				case (offset)
					soc_pkg::TIMER_REG_TIME: mtime <= i_wdata;
					soc_pkg::TIMER_REG_CMP: compare <= i_wdata;
					default: ;
				endcase
			end
		end
	end

	// Read data, unused offsets read zero
	always_ff @(posedge i_clock) begin
		if (access) begin
			case (offset)
				soc_pkg::TIMER_REG_TIME: o_rdata <= mtime;
				soc_pkg::TIMER_REG_CMP: o_rdata <= compare;
				default: o_rdata <= '0;
			endcase
		end
	end

endmodule

// File: src/dma_engine.sv
`timescale 1ns/1ps

module dma_engine (
	input  logic i_clock,
	input  logic i_rst,

	// Register slave
	input  logic i_request,
	input  logic i_rw,
	input  logic [soc_pkg::ADDR_W-1:0] i_address,
	input  logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,

	// Bus master
	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [soc_pkg::ADDR_W-1:0] o_bus_address,
	output logic [soc_pkg::DATA_W-1:0] o_bus_wdata,
	input  logic [soc_pkg::DATA_W-1:0] i_bus_rdata,
	input  logic i_bus_ready
);

	soc_pkg::dma_state_e state;

	logic [soc_pkg::ADDR_W-1:0] src;
	logic [soc_pkg::ADDR_W-1:0] dst;
	logic [soc_pkg::DATA_W-1:0] count;
	logic [soc_pkg::DATA_W-1:0] word;
	logic [1:0] offset;
	logic access;
	logic busy;

	assign offset = i_address[3:2];
	assign access = i_request && !o_ready;
	assign busy = state != soc_pkg::DMA_IDLE;

	// Master port follows the copy state and writes right after each read
	assign o_bus_request = busy;
	assign o_bus_rw = state == soc_pkg::DMA_WRITE;
	assign o_bus_address = (state == soc_pkg::DMA_WRITE) ? dst : src;
	assign o_bus_wdata = word;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= soc_pkg::DMA_IDLE;
			src <= '0;
			dst <= '0;
			count <= '0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= access;

			// Registers only take writes while idle
			if (access && i_rw && !busy) begin
				case (offset)
					soc_pkg::DMA_REG_SRC: src <= i_wdata;
					soc_pkg::DMA_REG_DST: dst <= i_wdata;
					soc_pkg::DMA_REG_COUNT: begin
						count <= i_wdata;
						if (i_wdata != '0) begin
							state <= soc_pkg::DMA_READ;
						end
					end
					default: ;
				endcase
			end

			case (state)
				soc_pkg::DMA_READ: begin
					if (i_bus_ready) begin
						src <= src + 32'd4;
						state <= soc_pkg::DMA_WRITE;
					end
				end
				soc_pkg::DMA_WRITE: begin
					if (i_bus_ready) begin
						dst <= dst + 32'd4;
						count <= count - 1'b1;
						state <= (count == 32'd1) ? soc_pkg::DMA_IDLE : soc_pkg::DMA_READ;
					end
				end
				default: ;
			endcase
		end
	end

	// Word in flight and register read data
	always_ff @(posedge i_clock) begin
		if (state == soc_pkg::DMA_READ && i_bus_ready) begin
			word <= i_bus_rdata;
		end
		if (access) begin
			case (offset)
				soc_pkg::DMA_REG_SRC: o_rdata <= src;
				soc_pkg::DMA_REG_DST: o_rdata <= dst;
				soc_pkg::DMA_REG_COUNT: o_rdata <= count;
				soc_pkg::DMA_REG_STATUS: o_rdata <= {{(soc_pkg::DATA_W - 1){1'b0}}, busy};
			endcase
		end
	end

endmodule

// File: src/soc_top.sv
`timescale 1ns/1ps

module soc_top (
	input  logic i_clock,
	input  logic i_rst,

	// Host port, where the CPU would sit
	input  logic i_host_request,
	input  logic i_host_rw,
	input  logic [soc_pkg::ADDR_W-1:0] i_host_address,
	input  logic [soc_pkg::DATA_W-1:0] i_host_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_host_rdata,
	output logic o_host_ready,

	output logic [soc_pkg::LED_W-1:0] o_led,
	output logic o_timer_irq
);

	// ====================================================================
	// System bus
	// ====================================================================

	logic bus_request;
	logic bus_rw;
	logic [soc_pkg::ADDR_W-1:0] bus_address;
	logic [soc_pkg::DATA_W-1:0] bus_wdata;
	logic [soc_pkg::DATA_W-1:0] bus_rdata;
	logic bus_ready;

	// DMA master port
	logic dma_bus_request;
	logic dma_bus_rw;
	logic [soc_pkg::ADDR_W-1:0] dma_bus_address;
	logic [soc_pkg::DATA_W-1:0] dma_bus_wdata;
	logic [soc_pkg::DATA_W-1:0] dma_bus_rdata;
	logic dma_bus_ready;

	// Slave side
	logic ram_request;
	logic [soc_pkg::DATA_W-1:0] ram_rdata;
	logic ram_ready;
	logic timer_request;
	logic [soc_pkg::DATA_W-1:0] timer_rdata;
	logic timer_ready;
	logic dma_request;
	logic [soc_pkg::DATA_W-1:0] dma_rdata;
	logic dma_ready;

	bus_arbiter arbiter (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_host_request(i_host_request), .i_host_rw(i_host_rw),
		.i_host_address(i_host_address), .i_host_wdata(i_host_wdata),
		.o_host_rdata(o_host_rdata), .o_host_ready(o_host_ready),
		.i_dma_request(dma_bus_request), .i_dma_rw(dma_bus_rw),
		.i_dma_address(dma_bus_address), .i_dma_wdata(dma_bus_wdata),
		.o_dma_rdata(dma_bus_rdata), .o_dma_ready(dma_bus_ready),
		.o_bus_request(bus_request), .o_bus_rw(bus_rw),
		.o_bus_address(bus_address), .o_bus_wdata(bus_wdata),
		.i_bus_rdata(bus_rdata), .i_bus_ready(bus_ready)
	);

	bus_fabric fabric (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_bus_request(bus_request), .i_bus_rw(bus_rw),
		.i_bus_address(bus_address), .i_bus_wdata(bus_wdata),
		.o_bus_rdata(bus_rdata), .o_bus_ready(bus_ready),
		.i_ram_rdata(ram_rdata), .i_ram_ready(ram_ready),
		.i_timer_rdata(timer_rdata), .i_timer_ready(timer_ready),
		.i_dma_rdata(dma_rdata), .i_dma_ready(dma_ready),
		.o_ram_request(ram_request),
		.o_timer_request(timer_request),
		.o_dma_request(dma_request),
		.o_led(o_led)
	);

	block_ram ram (
		.i_clock(i_clock),
		.i_request(ram_request), .i_rw(bus_rw),
		.i_address(bus_address), .i_wdata(bus_wdata),
		.o_rdata(ram_rdata), .o_ready(ram_ready)
	);

	timer timer0 (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_request(timer_request), .i_rw(bus_rw),
		.i_address(bus_address), .i_wdata(bus_wdata),
		.o_rdata(timer_rdata), .o_ready(timer_ready),
		.o_timer_irq(o_timer_irq)
	);

	dma_engine dma (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_request(dma_request), .i_rw(bus_rw),
		.i_address(bus_address), .i_wdata(bus_wdata),
		.o_rdata(dma_rdata), .o_ready(dma_ready),
		.o_bus_request(dma_bus_request), .o_bus_rw(dma_bus_rw),
		.o_bus_address(dma_bus_address), .o_bus_wdata(dma_bus_wdata),
		.i_bus_rdata(dma_bus_rdata), .i_bus_ready(dma_bus_ready)
	);

endmodule

// File: test/tb_soc_asserts.sv
`timescale 1ns/1ps

module tb_soc_asserts (
	input logic i_clock,
	input logic i_rst,
	input logic i_host_ready,
	input logic i_dma_ready,
	input logic i_bus_request,
	input logic i_bus_rw,
	input logic [soc_pkg::ADDR_W-1:0] i_bus_address,
	input logic [soc_pkg::DATA_W-1:0] i_bus_wdata,
	input logic i_bus_ready
);

	int fail_count = 0;

	// ====================================================================
	// Arbiter and bus protocol rules
	// ====================================================================

	// Completion goes to exactly one master
	property p_one_ready;
		@(posedge i_clock) disable iff (i_rst) !(i_host_ready && i_dma_ready);
	endproperty

	// Request and its fields hold until the slave answers
	property p_request_held;
		@(posedge i_clock) disable iff (i_rst)
			(i_bus_request && !i_bus_ready) |=>
				(i_bus_request && $stable(i_bus_rw) && $stable(i_bus_address)
				&& $stable(i_bus_wdata));
	endproperty

	property p_bus_ready_has_request;
		@(posedge i_clock) disable iff (i_rst) i_bus_ready |-> i_bus_request;
	endproperty

	// Master ready follows a completed bus transfer
	property p_master_ready_has_request;
		@(posedge i_clock) disable iff (i_rst)
			(i_host_ready || i_dma_ready) |-> $past(i_bus_request && i_bus_ready);
	endproperty

	a_one_ready: assert property (p_one_ready) else begin
		fail_count = fail_count + 1;
		$error("host and DMA ready high in the same cycle");
	end

	a_request_held: assert property (p_request_held) else begin
		fail_count = fail_count + 1;
		$error("bus request or its fields changed before bus ready");
	end

	a_bus_ready_has_request: assert property (p_bus_ready_has_request) else begin
		fail_count = fail_count + 1;
		$error("bus ready without a bus request");
	end

	a_master_ready_has_request: assert property (p_master_ready_has_request) else begin
		fail_count = fail_count + 1;
		$error("master ready without a completed bus transfer");
	end

endmodule

bind bus_arbiter tb_soc_asserts arb_checks (
	.i_clock(i_clock),
	.i_rst(i_rst),
	.i_host_ready(o_host_ready),
	.i_dma_ready(o_dma_ready),
	.i_bus_request(o_bus_request),
	.i_bus_rw(o_bus_rw),
	.i_bus_address(o_bus_address),
	.i_bus_wdata(o_bus_wdata),
	.i_bus_ready(i_bus_ready)
);

// File: test/tb_soc.sv
`timescale 1ns/1ps

module tb_soc;

	localparam int CLK_HALF = 4;
	localparam int MAX_STEPS = 128;
	localparam int RAM_WORDS = 16;
	localparam int DMA_WORDS = 8;
	localparam int READY_LIMIT = 100;
	localparam int POLL_LIMIT = 200;

	localparam logic [31:0] RAM_BASE = 32'h1000_0000;
	localparam logic [31:0] SRC_BASE = 32'h1000_0400;
	localparam logic [31:0] DST_BASE = 32'h1000_0600;
	localparam logic [31:0] LED_ADDR = 32'h4000_0000;
	localparam logic [31:0] DMA_BASE = 32'h9000_0000;
	localparam logic [31:0] TIMER_BASE = 32'ha000_0000;

	typedef enum logic [2:0] {
		OP_WRITE,
		OP_READ,
		OP_IDLE,
		OP_LED,
		OP_IRQ,
		OP_SET_CMP,
		OP_TIME_UP,
		OP_POLL
	} op_e;

	logic i_clock;
	logic i_rst;
	logic i_host_request;
	logic i_host_rw;
	logic [soc_pkg::ADDR_W-1:0] i_host_address;
	logic [soc_pkg::DATA_W-1:0] i_host_wdata;
	logic [soc_pkg::DATA_W-1:0] o_host_rdata;
	logic o_host_ready;
	logic [soc_pkg::LED_W-1:0] o_led;
	logic o_timer_irq;

	// Stimulus table
	op_e step_op [MAX_STEPS];
	logic [31:0] step_addr [MAX_STEPS];
	logic [31:0] step_wdata [MAX_STEPS];
	logic [31:0] step_exp [MAX_STEPS];
	string step_name [MAX_STEPS];
	int table_len;

	int errors;
	integer seed;
	logic [31:0] last_time;
	logic [31:0] ram_data [RAM_WORDS];
	logic [31:0] src_data [DMA_WORDS];

	soc_top dut (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_host_request(i_host_request), .i_host_rw(i_host_rw),
		.i_host_address(i_host_address), .i_host_wdata(i_host_wdata),
		.o_host_rdata(o_host_rdata), .o_host_ready(o_host_ready),
		.o_led(o_led), .o_timer_irq(o_timer_irq)
	);

	always #(CLK_HALF) i_clock = ~i_clock;

	function automatic logic [31:0] ram_addr(input int k);
		// Spread over the RAM so every index bit toggles
		return RAM_BASE + 32'(k) * 32'h7c;
	endfunction

	task automatic add_step(input op_e op, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [31:0] exp_val, input string name);
		step_op[table_len] = op;
		step_addr[table_len] = addr;
		step_wdata[table_len] = wdata;
		step_exp[table_len] = exp_val;
		step_name[table_len] = name;
		table_len++;
	endtask

	// One host transfer with request held until ready
	task automatic host_access(input logic rw, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(posedge i_clock);
		#1;
		i_host_request = 1'b1;
		i_host_rw = rw;
		i_host_address = addr;
		i_host_wdata = wdata;
		@(negedge i_clock);
		while (!o_host_ready && waited < READY_LIMIT) begin
			@(negedge i_clock);
			waited++;
		end
		if (!o_host_ready) begin
			errors++;
			$display("Host transfer to %h got no ready within %0d cycles", addr, READY_LIMIT);
		end
		rdata = o_host_rdata;
		@(posedge i_clock);
		#1;
		i_host_request = 1'b0;
	endtask

	task automatic build_table();
		int k;
		seed = 32'h5c72;
		table_len = 0;
		add_step(OP_IRQ, '0, '0, 32'd0, "irq after reset");
		add_step(OP_LED, '0, '0, 32'd0, "led after reset");

		// RAM pattern
		for (k = 0; k < RAM_WORDS; k++) begin
			ram_data[k] = $random(seed);
			add_step(OP_WRITE, ram_addr(k), ram_data[k], '0, "ram write");
		end
		for (k = 0; k < RAM_WORDS; k++) begin
			add_step(OP_READ, ram_addr(k), '0, ram_data[k], $sformatf("ram word %0d", k));
		end

		// LED register and unmapped space
		add_step(OP_WRITE, LED_ADDR, 32'h0000_02a5, '0, "led write");
		add_step(OP_LED, '0, '0, 32'h0000_02a5, "led pins");
		add_step(OP_READ, LED_ADDR, '0, 32'h0000_02a5, "led readback");
		add_step(OP_WRITE, LED_ADDR, 32'hffff_f155, '0, "led wide write");
		add_step(OP_LED, '0, '0, 32'h0000_0155, "led pins truncated");
		add_step(OP_READ, 32'h3000_0010, '0, '0, "unmapped read");
		add_step(OP_WRITE, 32'h7000_0000, 32'hdead_beef, '0, "unmapped write");
		add_step(OP_READ, 32'h7000_0000, '0, '0, "unmapped readback");
		add_step(OP_LED, '0, '0, 32'h0000_0155, "led after unmapped");

		// Timer compare and interrupt
		add_step(OP_SET_CMP, TIMER_BASE, 32'd50, '0, "timer compare readback");
		add_step(OP_IRQ, '0, '0, 32'd0, "irq before compare");
		add_step(OP_IDLE, '0, 32'd60, '0, "wait past compare");
		add_step(OP_IRQ, '0, '0, 32'd1, "irq after compare");
		add_step(OP_TIME_UP, TIMER_BASE, '0, '0, "time read 1");
		add_step(OP_TIME_UP, TIMER_BASE, '0, '0, "time read 2");

		// ================================================================
		// DMA copy with host traffic alongside
		// ================================================================
		for (k = 0; k < DMA_WORDS; k++) begin
			src_data[k] = $random(seed);
			add_step(OP_WRITE, SRC_BASE + 32'(4 * k), src_data[k], '0, "dma source write");
		end
		add_step(OP_WRITE, DMA_BASE, SRC_BASE, '0, "dma src write");
		add_step(OP_WRITE, DMA_BASE + 32'd4, DST_BASE, '0, "dma dst write");
		add_step(OP_READ, DMA_BASE, '0, SRC_BASE, "dma src readback");
		add_step(OP_READ, DMA_BASE + 32'd4, '0, DST_BASE, "dma dst readback");
		add_step(OP_WRITE, DMA_BASE + 32'd8, 32'(DMA_WORDS), '0, "dma start");
		for (k = 0; k < 4; k++) begin
			add_step(OP_READ, ram_addr(k), '0, ram_data[k], "ram read during dma");
			add_step(OP_READ, SRC_BASE + 32'(4 * k), '0, src_data[k], "source read during dma");
		end
		add_step(OP_POLL, DMA_BASE + 32'd12, 32'd1, 32'd0, "dma busy clear");
		for (k = 0; k < DMA_WORDS; k++) begin
			add_step(OP_READ, DST_BASE + 32'(4 * k), '0, src_data[k],
				$sformatf("dma dst word %0d", k));
		end
		add_step(OP_READ, DMA_BASE + 32'd8, '0, 32'd0, "dma count done");
		add_step(OP_READ, DMA_BASE, '0, SRC_BASE + 32'(4 * DMA_WORDS), "dma src advanced");
		add_step(OP_READ, DMA_BASE + 32'd4, '0, DST_BASE + 32'(4 * DMA_WORDS), "dma dst advanced");
		add_step(OP_READ, ram_addr(RAM_WORDS - 1), '0, ram_data[RAM_WORDS - 1], "ram after dma");
	endtask

	task automatic run_step(input int i);
		logic [31:0] rdata;
		logic [31:0] cmp;
		int polls;
		case (step_op[i])
			OP_WRITE: host_access(1'b1, step_addr[i], step_wdata[i], rdata);
			OP_READ: begin
				host_access(1'b0, step_addr[i], '0, rdata);
				if (rdata !== step_exp[i]) begin
					errors++;
					$display("ERR %s: expected %h, got %h", step_name[i], step_exp[i], rdata);
				end
			end
			OP_IDLE: repeat (step_wdata[i]) @(posedge i_clock);
			OP_LED: begin
				@(negedge i_clock);
				if (32'(o_led) !== step_exp[i]) begin
					errors++;
					$display("ERR %s: expected %h, got %h", step_name[i], step_exp[i], o_led);
				end
			end
			OP_IRQ: begin
				@(negedge i_clock);
				if (o_timer_irq !== step_exp[i][0]) begin
					errors++;
					$display("ERR %s: expected %b, got %b", step_name[i], step_exp[i][0],
						o_timer_irq);
				end
			end
			OP_SET_CMP: begin
				// Compare lands a fixed distance past the current time
				host_access(1'b0, step_addr[i], '0, rdata);
				last_time = rdata;
				cmp = rdata + step_wdata[i];
				host_access(1'b1, step_addr[i] + 32'd4, cmp, rdata);
				host_access(1'b0, step_addr[i] + 32'd4, '0, rdata);
				if (rdata !== cmp) begin
					errors++;
					$display("ERR %s: expected %h, got %h", step_name[i], cmp, rdata);
				end
			end
			OP_TIME_UP: begin
				host_access(1'b0, step_addr[i], '0, rdata);
				if (rdata <= last_time) begin
					errors++;
					$display("ERR %s: expected above %h, got %h", step_name[i], last_time, rdata);
				end
				last_time = rdata;
			end
			OP_POLL: begin
				polls = 0;
				host_access(1'b0, step_addr[i], '0, rdata);
				while ((rdata & step_wdata[i]) !== step_exp[i] && polls < POLL_LIMIT) begin
					host_access(1'b0, step_addr[i], '0, rdata);
					polls++;
				end
				if ((rdata & step_wdata[i]) !== step_exp[i]) begin
					errors++;
					$display("ERR %s: expected %h, got %h after %0d polls", step_name[i],
						step_exp[i], rdata & step_wdata[i], polls);
				end
			end
			default: ;
		endcase
	endtask

	initial begin
		int i;
		int assert_fails;
		i_clock = 1'b0;
		i_rst = 1'b1;
		i_host_request = 1'b0;
		i_host_rw = 1'b0;
		i_host_address = '0;
		i_host_wdata = '0;
		errors = 0;
		last_time = '0;
		build_table();
		repeat (2) @(posedge i_clock);
		#1;
		i_rst = 1'b0;
		for (i = 0; i < table_len; i++) begin
			run_step(i);
		end
		@(posedge i_clock);
		assert_fails = dut.arbiter.arb_checks.fail_count;
		$display("Done: %0d steps, %0d check errors, %0d assertion failures", table_len, errors,
			assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog sized from the table and the DMA copy
	initial begin
		int limit;
		@(negedge i_rst);
		limit = (table_len + DMA_WORDS) * 40;
		repeat (limit) @(posedge i_clock);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: flist.f
src/soc_pkg.sv
src/bus_arbiter.sv
src/bus_fabric.sv
src/block_ram.sv
src/timer.sv
src/dma_engine.sv
src/soc_top.sv
test/tb_soc_asserts.sv
test/tb_soc.sv

// File: Makefile
# Verilator build for the SoC bus testbench

VERILATOR   ?= verilator
TOP         ?= tb_soc
FLIST       ?= flist.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
PASS_MSG    ?= ALL CHECKS PASSED
LINT_FLAGS  ?= --lint-only -Wall --timing
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS    ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed, log in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
